// File: pwconv_pkg.sv
`default_nettype none

package pwconv_pkg;

    // Element widths of the datapath.
    localparam int ACT_WIDTH = 8;
    localparam int WEIGHT_WIDTH = 8;

    // Upper bound on the input and output channel counts.
    localparam int MAX_CHANNELS = 16;
    localparam int CHAN_WIDTH = $clog2(MAX_CHANNELS);

    // A full sum never overflows, even with MAX_CHANNELS terms and a bias.
    localparam int ACC_WIDTH = ACT_WIDTH + WEIGHT_WIDTH + 1 + CHAN_WIDTH;

    typedef bit [ACT_WIDTH-1:0] act_t;
    typedef bit signed [WEIGHT_WIDTH-1:0] weight_t;
    typedef bit signed [ACC_WIDTH-1:0] acc_t;
    typedef bit [CHAN_WIDTH-1:0] chan_t;

    // Tag that follows one cycle of work down the multiply-add chain.
    typedef struct packed {
        bit valid;
        chan_t out_channel;
    } seq_token_t;

    localparam int DEF_IN_CHANNELS = 3;
    localparam int DEF_OUT_CHANNELS = 4;

    // Indexed as [output channel][input channel].
    localparam weight_t [DEF_OUT_CHANNELS-1:0][DEF_IN_CHANNELS-1:0] DEF_WEIGHT = '{
        0: '{0: weight_t'(3), 1: weight_t'(-2), 2: weight_t'(7)},
        1: '{0: weight_t'(-128), 1: weight_t'(127), 2: weight_t'(1)},
        2: '{0: weight_t'(0), 1: weight_t'(-5), 2: weight_t'(-9)},
        3: '{0: weight_t'(12), 1: weight_t'(4), 2: weight_t'(-1)}
    };

    // One bias per output channel.
    localparam acc_t [DEF_OUT_CHANNELS-1:0] DEF_BIAS = '{
        0: acc_t'(10),
        1: acc_t'(-300),
        2: acc_t'(1000),
        3: acc_t'(-1)
    };

endpackage : pwconv_pkg

`default_nettype wire

// File: pwconv_delay_line.sv
`timescale 1ns/100ps
`default_nettype none

module pwconv_delay_line #(
    parameter type payload_t = bit,
    parameter int DEPTH = 1
) (
    input bit clock_i,
    input bit reset_i,
    input bit enable_i,
    input payload_t data_i,
    output payload_t data_o
);

    if (DEPTH == 0) begin : g_pass
        assign data_o = data_i;
    end : g_pass
    else begin : g_shift
        payload_t stages[DEPTH];

        // Every stage moves one step only when the pipeline is enabled.
        always_ff @(posedge clock_i) begin
            if (!reset_i) begin
                for (int index = 0; index < DEPTH; index++) begin
                    stages[index] <= '0;
                end
            end else if (enable_i) begin
                stages[0] <= data_i;
                for (int index = 1; index < DEPTH; index++) begin
                    stages[index] <= stages[index-1];
                end
            end
        end

        assign data_o = stages[DEPTH-1];
    end : g_shift

endmodule : pwconv_delay_line

`default_nettype wire

// File: pwconv_input_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module pwconv_input_sequencer
    import pwconv_pkg::*;
#(
    parameter int IN_CHANNELS = DEF_IN_CHANNELS,
    parameter int OUT_CHANNELS = DEF_OUT_CHANNELS
) (
    input bit clock_i,
    input bit reset_i,
    input bit slave_valid_i,
    input bit master_ready_i,
    input act_t [IN_CHANNELS-1:0] slave_data_i,
    output bit slave_ready_o,
    output seq_token_t token_o,
    output act_t [IN_CHANNELS-1:0] act_o
);

    localparam chan_t LAST_CHANNEL = chan_t'(OUT_CHANNELS - 1);

    // Output channel being computed for the element currently held at the input.
    chan_t channel;

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            channel <= '0;
        end else if (master_ready_i && slave_valid_i) begin
            channel <= (channel == LAST_CHANNEL) ? '0 : channel + chan_t'(1);
        end
    end

    // The element is consumed only in its last channel cycle.
    assign slave_ready_o = master_ready_i && (channel == LAST_CHANNEL);

    assign token_o.valid = slave_valid_i;
    assign token_o.out_channel = channel;

    assign act_o = slave_data_i;

endmodule : pwconv_input_sequencer

`default_nettype wire

// File: pwconv_mac_stage.sv
`timescale 1ns/100ps
`default_nettype none

module pwconv_mac_stage
    import pwconv_pkg::*;
#(
    parameter int STAGE = 0,
    parameter int IN_CHANNELS = DEF_IN_CHANNELS,
    parameter int OUT_CHANNELS = DEF_OUT_CHANNELS,
    parameter weight_t [OUT_CHANNELS-1:0][IN_CHANNELS-1:0] WEIGHT = DEF_WEIGHT
) (
    input bit clock_i,
    input bit reset_i,
    input bit enable_i,
    input act_t act_i,
    input seq_token_t token_i,
    input acc_t psum_i,
    output seq_token_t token_o,
    output acc_t psum_o
);

    // Picks this stage's weight for one output channel; unused channels read as zero.
    function automatic weight_t select_weight(chan_t channel);
        weight_t weight;
        weight = '0;
        for (int out_channel = 0; out_channel < OUT_CHANNELS; out_channel++) begin
            if (chan_t'(out_channel) == channel) begin
                weight = WEIGHT[out_channel][STAGE];
            end
        end
        return weight;
    endfunction : select_weight

    act_t act_delayed;
    weight_t weight;
    acc_t product;

    // The token reaches stage k k cycles after it left the sequencer,
    // so the activation is skewed by the same amount.
    pwconv_delay_line #(
        .payload_t(act_t),
        .DEPTH(STAGE)
    ) u_act_skew (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .enable_i(enable_i),
        .data_i(act_i),
        .data_o(act_delayed)
    );

    assign weight = select_weight(token_i.out_channel);

    // Activations are unsigned, so a zero sign bit is added before the signed multiply.
    assign product = acc_t'(weight) * acc_t'($signed({1'b0, act_delayed}));

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            token_o <= '0;
        end else if (enable_i) begin
            token_o <= token_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (enable_i) begin
            psum_o <= psum_i + product;
        end
    end

endmodule : pwconv_mac_stage

`default_nettype wire

// File: pwconv_mac_chain.sv
`timescale 1ns/100ps
`default_nettype none

module pwconv_mac_chain
    import pwconv_pkg::*;
#(
    parameter int IN_CHANNELS = DEF_IN_CHANNELS,
    parameter int OUT_CHANNELS = DEF_OUT_CHANNELS,
    parameter weight_t [OUT_CHANNELS-1:0][IN_CHANNELS-1:0] WEIGHT = DEF_WEIGHT,
    parameter acc_t [OUT_CHANNELS-1:0] BIAS = DEF_BIAS
) (
    input bit clock_i,
    input bit reset_i,
    input bit enable_i,
    input seq_token_t token_i,
    input act_t [IN_CHANNELS-1:0] act_i,
    output seq_token_t token_o,
    output acc_t result_o
);

    // Bias of one output channel, zero for channels past OUT_CHANNELS.
    function automatic acc_t select_bias(chan_t channel);
        acc_t bias;
        bias = '0;
        for (int out_channel = 0; out_channel < OUT_CHANNELS; out_channel++) begin
            if (chan_t'(out_channel) == channel) begin
                bias = BIAS[out_channel];
            end
        end
        return bias;
    endfunction : select_bias

    // Link k feeds stage k; the last link is the chain output.
    seq_token_t tokens[IN_CHANNELS+1];
    acc_t psums[IN_CHANNELS+1];

    assign tokens[0] = token_i;
    assign psums[0] = select_bias(token_i.out_channel);

    for (genvar stage = 0; stage < IN_CHANNELS; stage++) begin : g_stage
        pwconv_mac_stage #(
            .STAGE(stage),
            .IN_CHANNELS(IN_CHANNELS),
            .OUT_CHANNELS(OUT_CHANNELS),
            .WEIGHT(WEIGHT)
        ) u_mac_stage (
            .clock_i(clock_i),
            .reset_i(reset_i),
            .enable_i(enable_i),
            .act_i(act_i[stage]),
            .token_i(tokens[stage]),
            .psum_i(psums[stage]),
            .token_o(tokens[stage+1]),
            .psum_o(psums[stage+1])
        );
    end : g_stage

    assign token_o = tokens[IN_CHANNELS];
    assign result_o = psums[IN_CHANNELS];

endmodule : pwconv_mac_chain

`default_nettype wire

// File: pwconv_output_collector.sv
`timescale 1ns/100ps
`default_nettype none

module pwconv_output_collector
    import pwconv_pkg::*;
#(
    parameter int OUT_CHANNELS = DEF_OUT_CHANNELS
) (
    input bit clock_i,
    input bit reset_i,
    input bit master_ready_i,
    input seq_token_t token_i,
    input acc_t result_i,
    output bit master_valid_o,
    output act_t [OUT_CHANNELS-1:0] master_data_o
);

    localparam chan_t LAST_CHANNEL = chan_t'(OUT_CHANNELS - 1);

    // Only the low bits of each sum leave the core.
    act_t result_low;

    assign result_low = act_t'(result_i);

    // The last channel of an element completes the output vector.
    assign master_valid_o = token_i.valid && (token_i.out_channel == LAST_CHANNEL);

    for (genvar channel = 0; channel < OUT_CHANNELS; channel++) begin : g_channel
        if (channel == OUT_CHANNELS - 1) begin : g_last
            // Presented straight from the chain, in the same cycle as master_valid_o.
            assign master_data_o[channel] = result_low;
        end : g_last
        else begin : g_buffered
            act_t buffer;

            // Earlier channels wait here until the last one arrives.
            always_ff @(posedge clock_i) begin
                if (!reset_i) begin
                    buffer <= '0;
                end else if (master_ready_i && token_i.valid &&
                             token_i.out_channel == chan_t'(channel)) begin
                    buffer <= result_low;
                end
            end

            assign master_data_o[channel] = buffer;
        end : g_buffered
    end : g_channel

endmodule : pwconv_output_collector

`default_nettype wire

// File: pwconv_top.sv
`timescale 1ns/100ps
`default_nettype none

module pwconv_top
    import pwconv_pkg::*;
#(
    parameter int IN_CHANNELS = DEF_IN_CHANNELS,
    parameter int OUT_CHANNELS = DEF_OUT_CHANNELS,
    parameter weight_t [OUT_CHANNELS-1:0][IN_CHANNELS-1:0] WEIGHT = DEF_WEIGHT,
    parameter acc_t [OUT_CHANNELS-1:0] BIAS = DEF_BIAS
) (
    input bit clock_i,
    input bit reset_i,

    input bit slave_valid_i,
    output bit slave_ready_o,
    input act_t [IN_CHANNELS-1:0] slave_data_i,

    output bit master_valid_o,
    input bit master_ready_i,
    output act_t [OUT_CHANNELS-1:0] master_data_o
);

    seq_token_t seq_token;
    act_t [IN_CHANNELS-1:0] seq_act;
    seq_token_t chain_token;
    acc_t chain_result;

    pwconv_input_sequencer #(
        .IN_CHANNELS(IN_CHANNELS),
        .OUT_CHANNELS(OUT_CHANNELS)
    ) u_sequencer (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .slave_valid_i(slave_valid_i),
        .master_ready_i(master_ready_i),
        .slave_data_i(slave_data_i),
        .slave_ready_o(slave_ready_o),
        .token_o(seq_token),
        .act_o(seq_act)
    );

    // master_ready_i acts as the clock enable of the whole pipeline.
    pwconv_mac_chain #(
        .IN_CHANNELS(IN_CHANNELS),
        .OUT_CHANNELS(OUT_CHANNELS),
        .WEIGHT(WEIGHT),
        .BIAS(BIAS)
    ) u_mac_chain (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .enable_i(master_ready_i),
        .token_i(seq_token),
        .act_i(seq_act),
        .token_o(chain_token),
        .result_o(chain_result)
    );

    pwconv_output_collector #(
        .OUT_CHANNELS(OUT_CHANNELS)
    ) u_collector (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .master_ready_i(master_ready_i),
        .token_i(chain_token),
        .result_i(chain_result),
        .master_valid_o(master_valid_o),
        .master_data_o(master_data_o)
    );

endmodule : pwconv_top

`default_nettype wire

// File: pwconv_sva.sv
`timescale 1ns/100ps
`default_nettype none

module pwconv_sva
    import pwconv_pkg::*;
#(
    parameter int OUT_CHANNELS = DEF_OUT_CHANNELS
) (
    input bit clock_i,
    input bit reset_i,
    input bit slave_ready_o,
    input bit master_valid_o,
    input bit master_ready_i,
    input act_t [OUT_CHANNELS-1:0] master_data_o
);

    // The first reset edge clears every token, so no vector is offered afterwards.
    valid_low_in_reset: assert property (@(posedge clock_i) !reset_i |=> !master_valid_o)
        else $error("master_valid_o is high while reset is asserted");

    // A stalled output vector must not change before it is taken.
    data_stable_when_stalled: assert property (@(posedge clock_i) disable iff (!reset_i)
        master_valid_o && !master_ready_i |=> $stable(master_data_o))
        else $error("master_data_o changed while the output was stalled");

    // The input is accepted only when the pipeline can advance.
    ready_needs_enable: assert property (@(posedge clock_i) slave_ready_o |-> master_ready_i)
        else $error("slave_ready_o is high while master_ready_i is low");

endmodule : pwconv_sva

bind pwconv_top pwconv_sva #(
    .OUT_CHANNELS(OUT_CHANNELS)
) u_sva (
    .clock_i(clock_i),
    .reset_i(reset_i),
    .slave_ready_o(slave_ready_o),
    .master_valid_o(master_valid_o),
    .master_ready_i(master_ready_i),
    .master_data_o(master_data_o)
);

`default_nettype wire

// File: tb_pwconv.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pwconv
    import pwconv_pkg::*;
;

    localparam int IN_CHANNELS = DEF_IN_CHANNELS;
    localparam int OUT_CHANNELS = DEF_OUT_CHANNELS;
    localparam int CLK_PERIOD = 20;
    localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
    localparam int STREAM_LENGTH = 20;

    // Single vector, reset vector, three extreme vectors and two random streams.
    localparam int TOTAL_VECTORS = 1 + 1 + 3 + 2 * STREAM_LENGTH;

    // Back-pressure in the last stream can stretch each vector up to twice its length.
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_VECTORS * OUT_CHANNELS + IN_CHANNELS + 50;

    typedef act_t [IN_CHANNELS-1:0] in_vec_t;
    typedef act_t [OUT_CHANNELS-1:0] out_vec_t;

    bit clock_i = 1'b0;
    bit reset_i;
    bit slave_valid_i;
    bit slave_ready_o;
    in_vec_t slave_data_i;
    bit master_valid_o;
    bit master_ready_i;
    out_vec_t master_data_o;

    bit [31:0] rng_state = 32'd88359;
    out_vec_t expected_queue[$];
    int error_count = 0;
    int check_count = 0;
    int sent_count = 0;
    int received_count = 0;

    pwconv_top DUT (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .slave_valid_i(slave_valid_i),
        .slave_ready_o(slave_ready_o),
        .slave_data_i(slave_data_i),
        .master_valid_o(master_valid_o),
        .master_ready_i(master_ready_i),
        .master_data_o(master_data_o)
    );

    always #(CLK_PERIOD / 2) clock_i = ~clock_i;

    function automatic bit [31:0] xorshift32(bit [31:0] state);
        bit [31:0] x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction : xorshift32

    // Bias plus signed weight times unsigned activation, low ACT_WIDTH bits kept.
    function automatic out_vec_t model_output(in_vec_t acts);
        out_vec_t result;
        int sum;
        for (int out_ch = 0; out_ch < OUT_CHANNELS; out_ch++) begin
            sum = int'(DEF_BIAS[out_ch]);
            for (int in_ch = 0; in_ch < IN_CHANNELS; in_ch++) begin
                sum += int'(DEF_WEIGHT[out_ch][in_ch]) * int'(acts[in_ch]);
            end
            result[out_ch] = act_t'(sum[ACT_WIDTH-1:0]);
        end
        return result;
    endfunction : model_output

    task automatic random_vector(output in_vec_t data);
        for (int in_ch = 0; in_ch < IN_CHANNELS; in_ch++) begin
            rng_state = xorshift32(rng_state);
            data[in_ch] = act_t'(rng_state[7:0]);
        end
    endtask : random_vector

    task automatic expect_low(string name, bit actual);
        check_count++;
        if (actual) begin
            error_count++;
            $display("[FAIL] %s: expected 0x0, got 0x%0h", name, actual);
        end
    endtask : expect_low

    task automatic check_output(out_vec_t actual);
        out_vec_t expected;
        received_count++;
        if (expected_queue.size() == 0) begin
            error_count++;
            $display("Output vector 0x%h appeared with no input vector pending", actual);
        end else begin
            expected = expected_queue.pop_front();
            for (int channel = 0; channel < OUT_CHANNELS; channel++) begin
                check_count++;
                if (actual[channel] != expected[channel]) begin
                    error_count++;
                    $display("[FAIL] master_data_o[%0d]: expected 0x%02h, got 0x%02h",
                             channel, expected[channel], actual[channel]);
                end
            end
        end
    endtask : check_output

    // Holds one vector at the input until it is accepted; called on a falling edge.
    task automatic present_vector(in_vec_t data, bit throttle);
        bit accepted;
        accepted = 1'b0;
        slave_valid_i = 1'b1;
        slave_data_i = data;
        while (!accepted) begin
            if (throttle) begin
                rng_state = xorshift32(rng_state);
                master_ready_i = (rng_state[1:0] != 2'b00);
            end
            #(SAMPLE_DELAY);
            if (slave_ready_o) begin
                accepted = 1'b1;
                expected_queue.push_back(model_output(data));
                sent_count++;
            end
            @(negedge clock_i);
        end
    endtask : present_vector

    task automatic drain();
        slave_valid_i = 1'b0;
        master_ready_i = 1'b1;
        while (expected_queue.size() != 0) begin
            @(negedge clock_i);
        end
        // A duplicated vector would still be on its way through the chain.
        repeat (IN_CHANNELS + OUT_CHANNELS) @(negedge clock_i);
        check_count++;
        if (received_count != sent_count) begin
            error_count++;
            $display("Received %0d output vectors for %0d input vectors",
                     received_count, sent_count);
        end
    endtask : drain

    task automatic test_idle_after_reset();
        slave_valid_i = 1'b0;
        master_ready_i = 1'b1;
        repeat (8) begin
            #(SAMPLE_DELAY);
            expect_low("slave_ready_o", slave_ready_o);
            expect_low("master_valid_o", master_valid_o);
            @(negedge clock_i);
        end
    endtask : test_idle_after_reset

    task automatic test_single_vector();
        in_vec_t data;
        int edges;
        random_vector(data);
        present_vector(data, 1'b0);
        slave_valid_i = 1'b0;
        // The accepting edge is the first one counted.
        edges = 1;
        #(SAMPLE_DELAY);
        while (!master_valid_o && edges <= 4 * IN_CHANNELS) begin
            @(negedge clock_i);
            edges++;
            #(SAMPLE_DELAY);
        end
        check_count++;
        if (!master_valid_o) begin
            error_count++;
            $display("master_valid_o never rose after the single vector was accepted");
        end else if (edges != IN_CHANNELS) begin
            error_count++;
            $display("[FAIL] master_valid_o latency: expected 0x%0h edges, got 0x%0h",
                     IN_CHANNELS, edges);
        end
        @(negedge clock_i);
        drain();
    endtask : test_single_vector

    // A reset while a vector is still inside the chain drops that vector.
    task automatic test_reset_in_flight();
        in_vec_t data;
        random_vector(data);
        present_vector(data, 1'b0);
        slave_valid_i = 1'b0;
        reset_i = 1'b0;
        expected_queue.delete();
        sent_count--;
        repeat (2) @(negedge clock_i);
        reset_i = 1'b1;
        test_idle_after_reset();
    endtask : test_reset_in_flight

    task automatic test_extreme_values();
        present_vector('1, 1'b0);
        present_vector('0, 1'b0);
        present_vector({act_t'(8'hff), act_t'(8'h00), act_t'(8'hff)}, 1'b0);
        drain();
    endtask : test_extreme_values

    task automatic test_stream(bit throttle);
        in_vec_t data;
        for (int index = 0; index < STREAM_LENGTH; index++) begin
            random_vector(data);
            present_vector(data, throttle);
        end
        drain();
    endtask : test_stream

    always begin
        @(negedge clock_i);
        #(SAMPLE_DELAY);
        if (reset_i && master_valid_o && master_ready_i) begin
            check_output(master_data_o);
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock_i);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        reset_i = 1'b0;
        slave_valid_i = 1'b0;
        slave_data_i = '0;
        master_ready_i = 1'b1;
        repeat (2) @(posedge clock_i);
        @(negedge clock_i);
        reset_i = 1'b1;

        test_idle_after_reset();
        test_single_vector();
        test_reset_in_flight();
        test_extreme_values();
        test_stream(1'b0);
        test_stream(1'b1);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_pwconv

`default_nettype wire

// File: build.f
pwconv_pkg.sv
pwconv_delay_line.sv
pwconv_input_sequencer.sv
pwconv_mac_stage.sv
pwconv_mac_chain.sv
pwconv_output_collector.sv
pwconv_top.sv
pwconv_sva.sv
tb_pwconv.sv

// File: run.sh
#!/bin/sh
# Builds the pwconv testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
    --top-module tb_pwconv \
    -f build.f \
    -o tb_pwconv_sim

# The log decides the outcome, so a non-zero exit of the simulator is kept for grep.
./obj_dir/tb_pwconv_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi
